//--- eth_tx_pkg.sv
`default_nettype none

package eth_tx_pkg;

	////////////////////////////////////////
	// Widths

	// APB byte address, 4 KB window
	localparam int APB_ADDR_WIDTH = 12;

	// Frame length in bytes, longest frame 2047
	localparam int LEN_WIDTH = 11;

	////////////////////////////////////////
	// Register map

	typedef enum logic [APB_ADDR_WIDTH-1:0] {
		// Bit 0 = link up, read only
		REG_STAT   = 12'h000,
		// Any write sends the frame built so far
		REG_COMMIT = 12'h004,
		// This offset and everything above is frame data
		REG_TX_BUF = 12'h010
	} reg_addr_t;

	////////////////////////////////////////
	// Frame sender states

	typedef enum logic [1:0] {
		// Waiting for a queued length
		TX_IDLE = 2'd0,
		// Length popped, first byte goes out next
		TX_LOAD = 2'd1,
		// Remaining bytes, one per cycle
		TX_SEND = 2'd2
	} tx_state_t;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  wire logic                       clk,
	input  wire logic                       rst_n,
	input  wire logic                       flush,
	input  wire logic                       push,
	input  wire logic [WIDTH-1:0]           wdata,
	input  wire logic                       pop,
	output logic      [WIDTH-1:0]           rdata,
	output logic                            empty,
	output logic                            full,
	output logic      [$clog2(DEPTH+1)-1:0] free
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Overflowing pushes and underflowing pops are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	assign free  = CNT_W'(DEPTH) - count;

	// Show-ahead head entry
	assign rdata = mem[rd_ptr];

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// Drop everything in one cycle
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Explicit wrap keeps odd depths working
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- apb_tx_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_tx_regs #(
	parameter int DATA_DEPTH = 2048
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_n,
	input  wire logic                                   psel,
	input  wire logic                                   penable,
	input  wire logic                                   pwrite,
	input  wire logic [$bits(eth_tx_pkg::reg_addr_t)-1:0] paddr,
	input  wire logic [31:0]                            pwdata,
	input  wire logic [3:0]                             pstrb,
	output logic                                        pready,
	output logic      [31:0]                            prdata,
	output logic                                        pslverr,
	input  wire logic                                   link_up,
	input  wire logic [$clog2(DATA_DEPTH+1)-1:0]        byte_free,
	input  wire logic                                   len_full,
	output logic                                        byte_push,
	output logic      [7:0]                             byte_data,
	output logic                                        len_push,
	output logic      [eth_tx_pkg::LEN_WIDTH-1:0]       len_data
);

	import eth_tx_pkg::*;

	logic [23:0]          pend_data;
	logic [1:0]           pend_cnt;
	logic [LEN_WIDTH-1:0] byte_cnt;
	logic                 wr_accept;
	logic                 data_wr;
	logic                 commit_wr;

	////////////////////////////////////////
	// APB response

	// Hold off while the serializer is busy, including the byte in flight,
	// so byte_free is exact when a new word is taken
	assign pready = psel && penable && (pend_cnt == 2'd0) && !byte_push
		&& (byte_free >= 4) && !len_full;

	// Status is read only, everything else is write only
	assign pslverr = pready && (pwrite ? (paddr == REG_STAT) : (paddr != REG_STAT));

	always_comb begin
		prdata = '0;
		if (pready && !pwrite && (paddr == REG_STAT))
			prdata = {31'b0, link_up};
	end

	// Writes taken during link down fall on the floor
	assign wr_accept = pready && pwrite && link_up;
	assign data_wr   = wr_accept && (paddr >= REG_TX_BUF);
	assign commit_wr = wr_accept && (paddr == REG_COMMIT);

	////////////////////////////////////////
	// Word to byte serializer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_push <= 1'b0;
			pend_cnt  <= 2'd0;
			len_push  <= 1'b0;
			byte_cnt  <= '0;
		end else if (!link_up) begin
			// Partial frame is thrown away
			byte_push <= 1'b0;
			pend_cnt  <= 2'd0;
			len_push  <= 1'b0;
			byte_cnt  <= '0;
		end else begin
			byte_push <= 1'b0;
			len_push  <= 1'b0;

			// Count every byte that enters the FIFO
			if (byte_push)
				byte_cnt <= byte_cnt + 1'b1;

			// Drain the upper bytes of the last word
			if (pend_cnt != 2'd0) begin
				byte_push <= 1'b1;
				pend_cnt  <= pend_cnt - 1'b1;
			end

			// Low byte goes out first, strobes assumed contiguous from bit 0
			if (data_wr) begin
				byte_push <= 1'b1;
				if (pstrb[3])
					pend_cnt <= 2'd3;
				else if (pstrb[2])
					pend_cnt <= 2'd2;
				else if (pstrb[1])
					pend_cnt <= 2'd1;
			end

			// Empty frames are not queued
			if (commit_wr) begin
				len_push <= (byte_cnt != '0);
				byte_cnt <= '0;
			end
		end
	end

	// Byte and length payload
	always_ff @(posedge clk) begin
		if (data_wr) begin
			byte_data <= pwdata[7:0];
			pend_data <= pwdata[31:8];
		end else if (pend_cnt != 2'd0) begin
			byte_data <= pend_data[7:0];
			pend_data <= {8'h00, pend_data[23:8]};
		end
		if (commit_wr)
			len_data <= byte_cnt;
	end

endmodule

`default_nettype wire

//--- frame_sender.sv
`timescale 1ns/10ps
`default_nettype none

module frame_sender (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             tx_ready,
	input  wire logic                             len_empty,
	input  wire logic [eth_tx_pkg::LEN_WIDTH-1:0] len_head,
	output logic                                  len_pop,
	input  wire logic [7:0]                       byte_head,
	output logic                                  byte_pop,
	output logic                                  tx_valid,
	output logic                                  tx_start,
	output logic      [7:0]                       tx_data
);

	import eth_tx_pkg::*;

	tx_state_t            state;
	logic [LEN_WIDTH-1:0] frame_len;
	logic [LEN_WIDTH-1:0] tx_count;
	logic                 send_more;

	////////////////////////////////////////
	// FIFO pops

	// More bytes left in the current frame
	assign send_more = (tx_count < frame_len);

	// Lengths are only queued once all their bytes are in the byte FIFO
	assign len_pop  = (state == TX_IDLE) && !len_empty && tx_ready;
	assign byte_pop = (state == TX_LOAD) || ((state == TX_SEND) && send_more);

	////////////////////////////////////////
	// State machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			tx_count <= '0;
			tx_valid <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				TX_IDLE: begin
					tx_valid <= 1'b0;
					if (len_pop)
						state <= TX_LOAD;
				end
				TX_LOAD: begin
					// First byte carries the start flag
					tx_valid <= 1'b1;
					tx_start <= 1'b1;
					tx_count <= LEN_WIDTH'(1);
					state    <= TX_SEND;
				end
				TX_SEND: begin
					// Never paused once started
					if (send_more) begin
						tx_valid <= 1'b1;
						tx_count <= tx_count + 1'b1;
					end else begin
						tx_valid <= 1'b0;
						state    <= TX_IDLE;
					end
				end
				default: begin
					tx_valid <= 1'b0;
					state    <= TX_IDLE;
				end
			endcase
		end
	end

	// Length and data payload
	always_ff @(posedge clk) begin
		if (len_pop)
			frame_len <= len_head;
		if (byte_pop)
			tx_data <= byte_head;
	end

endmodule

`default_nettype wire

//--- eth_tx_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_buffer #(
	parameter int DATA_DEPTH = 2048,
	parameter int LEN_DEPTH  = 32
) (
	input  wire logic                                  apb,
	input  wire logic                                  rst_n,
	input  wire logic                                  psel,
	input  wire logic                                  penable,
	input  wire logic                                  pwrite,
	input  wire logic [eth_tx_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input  wire logic [31:0]                           pwdata,
	input  wire logic [3:0]                            pstrb,
	output logic                                       pready,
	output logic      [31:0]                           prdata,
	output logic                                       pslverr,
	input  wire logic                                  link_up,
	input  wire logic                                  tx_ready,
	output logic                                       tx_valid,
	output logic                                       tx_start,
	output logic      [7:0]                            tx_data
);

	import eth_tx_pkg::*;

	logic                               fifo_flush;
	logic                               byte_push;
	logic [7:0]                         byte_data;
	logic [$clog2(DATA_DEPTH+1)-1:0]    byte_free;
	logic                               byte_pop;
	logic [7:0]                         byte_head;
	logic                               len_push;
	logic [LEN_WIDTH-1:0]               len_data;
	logic                               len_full;
	logic                               len_pop;
	logic [LEN_WIDTH-1:0]               len_head;
	logic                               len_empty;

	// Both queues stay empty while the link is down
	assign fifo_flush = !link_up;

	////////////////////////////////////////
	// APB front end

	apb_tx_regs #(
		.DATA_DEPTH(DATA_DEPTH)
	) u_regs (
		.clk(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.link_up(link_up),
		.byte_free(byte_free),
		.len_full(len_full),
		.byte_push(byte_push),
		.byte_data(byte_data),
		.len_push(len_push),
		.len_data(len_data)
	);

	////////////////////////////////////////
	// Frame byte and length queues

	sync_fifo #(
		.WIDTH(8),
		.DEPTH(DATA_DEPTH)
	) u_byte_fifo (
		.clk(apb),
		.rst_n(rst_n),
		.flush(fifo_flush),
		.push(byte_push),
		.wdata(byte_data),
		.pop(byte_pop),
		.rdata(byte_head),
		.empty(),
		.full(),
		.free(byte_free)
	);

	sync_fifo #(
		.WIDTH(LEN_WIDTH),
		.DEPTH(LEN_DEPTH)
	) u_len_fifo (
		.clk(apb),
		.rst_n(rst_n),
		.flush(fifo_flush),
		.push(len_push),
		.wdata(len_data),
		.pop(len_pop),
		.rdata(len_head),
		.empty(len_empty),
		.full(len_full),
		.free()
	);

	////////////////////////////////////////
	// Transmit side

	frame_sender u_sender (
		.clk(apb),
		.rst_n(rst_n),
		.tx_ready(tx_ready),
		.len_empty(len_empty),
		.len_head(len_head),
		.len_pop(len_pop),
		.byte_head(byte_head),
		.byte_pop(byte_pop),
		.tx_valid(tx_valid),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	// Free running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset low from time zero, released on a falling edge
	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- eth_tx_buffer_properties.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_buffer_properties (
	input wire logic apb,
	input wire logic rst_n,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic tx_valid,
	input wire logic tx_start
);

	// Number of failed assertions so far
	int fail_count = 0;

	// Error response only on a completing transfer
	slverr_with_ready: assert property (@(posedge apb) disable iff (!rst_n)
		pslverr |-> pready)
		else begin
			fail_count++;
			$error("pslverr high without pready");
		end

	// Completion only inside an access phase
	ready_in_access: assert property (@(posedge apb) disable iff (!rst_n)
		pready |-> (psel && penable))
		else begin
			fail_count++;
			$error("pready high outside an access phase");
		end

	// Start flag rides on a valid byte
	start_with_valid: assert property (@(posedge apb) disable iff (!rst_n)
		tx_start |-> tx_valid)
		else begin
			fail_count++;
			$error("tx_start high without tx_valid");
		end

	// Transmit port quiet in reset
	quiet_in_reset: assert property (@(posedge apb)
		!rst_n |-> (!tx_valid && !tx_start))
		else begin
			fail_count++;
			$error("transmit port active during reset");
		end

endmodule

bind eth_tx_buffer eth_tx_buffer_properties u_props (
	.apb(apb),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.tx_valid(tx_valid),
	.tx_start(tx_start)
);

`default_nettype wire

//--- eth_tx_buffer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module eth_tx_buffer_tb;

	import eth_tx_pkg::*;

	localparam string TRACE_FILE  = "eth_tx_trace.txt";
	localparam int    LINE_CYCLES = 200;
	localparam int    SETTLE      = 1;

	logic                      apb;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [APB_ADDR_WIDTH-1:0] paddr;
	logic [31:0]               pwdata;
	logic [3:0]                pstrb;
	logic                      pready;
	logic [31:0]               prdata;
	logic                      pslverr;
	logic                      link_up;
	logic                      tx_ready = 1'b0;
	logic                      tx_valid;
	logic                      tx_start;
	logic [7:0]                tx_data;

	// Trace line split into opcode and hex values
	byte                  op;
	int unsigned          fields[$];
	// Expected and received frames, bytes kept flat
	logic [LEN_WIDTH-1:0] exp_lens[$];
	logic [7:0]           exp_bytes[$];
	logic [LEN_WIDTH-1:0] rx_lens[$];
	logic [7:0]           rx_bytes[$];
	logic [LEN_WIDTH-1:0] cur_len;
	bit                   in_frame = 1'b0;
	// tx_ready mode 0 low, 1 high, 2 random
	logic [1:0]           tx_mode = 2'd0;
	integer               seed = 32'h622f_fcd7;
	logic [31:0]          rnd;
	int                   cycles = 0;
	int                   cycle_limit = 0;

	tb_clock_gen #(
		.PERIOD_NS(20),
		.RESET_CYCLES(3)
	) u_clk (
		.clk(apb),
		.rst_n(rst_n)
	);

	eth_tx_buffer #(
		.DATA_DEPTH(32),
		.LEN_DEPTH(32)
	) dut (
		.apb(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.pready(pready),
		.prdata(prdata),
		.pslverr(pslverr),
		.link_up(link_up),
		.tx_ready(tx_ready),
		.tx_valid(tx_valid),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	////////////////////////////////////////
	// Failure and compare tasks

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: prdata is %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_slverr(input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: pslverr is %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: tx_data is %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input logic [LEN_WIDTH-1:0] got, input logic [LEN_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: frame length is %0d, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// Trace parsing

	function automatic int hex_value(input byte c);
		if (c >= "0" && c <= "9")
			return c - "0";
		if (c >= "a" && c <= "f")
			return c - "a" + 10;
		if (c >= "A" && c <= "F")
			return c - "A" + 10;
		return -1;
	endfunction

	// First printable character is the opcode, then hex values
	task automatic split_fields(input string text);
		int unsigned val;
		int          digit;
		bit          in_token;
		fields.delete();
		op = 8'h00;
		val = 0;
		in_token = 1'b0;
		for (int i = 0; i < text.len(); i++) begin
			digit = hex_value(text.getc(i));
			if (op == 8'h00) begin
				if (text.getc(i) > 8'h20)
					op = text.getc(i);
			end else if (digit >= 0) begin
				val = (val << 4) | digit;
				in_token = 1'b1;
			end else if (in_token) begin
				fields.push_back(val);
				val = 0;
				in_token = 1'b0;
			end
		end
		if (in_token)
			fields.push_back(val);
	endtask

	task automatic need_fields(input int line_no, input int n);
		if (fields.size() < n) begin
			$display("Trace line %0d has too few values", line_no);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// APB driver and frame drain

	// Setup, then access until pready, then idle
	task automatic apb_xfer(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
		input logic [3:0] strb, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge apb);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		pstrb = strb;
		@(negedge apb);
		penable = 1'b1;
		#SETTLE;
		while (!pready) begin
			@(negedge apb);
			#SETTLE;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge apb);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pstrb = 4'h0;
	endtask

	// Wait for every expected frame, then compare in order
	task automatic drain_frames();
		logic [LEN_WIDTH-1:0] exp_len;
		logic [LEN_WIDTH-1:0] got_len;
		while (rx_lens.size() < exp_lens.size())
			@(negedge apb);
		while (exp_lens.size() > 0) begin
			exp_len = exp_lens.pop_front();
			got_len = rx_lens.pop_front();
			check_len(got_len, exp_len);
			repeat (exp_len)
				check_byte(rx_bytes.pop_front(), exp_bytes.pop_front());
		end
	endtask

	task automatic run_op(input int line_no);
		logic [31:0]          got_data;
		logic                 got_err;
		logic [LEN_WIDTH-1:0] n;
		case (op)
			"W": begin
				need_fields(line_no, 4);
				apb_xfer(1'b1, APB_ADDR_WIDTH'(fields[0]), 4'(fields[1]), fields[2],
					got_data, got_err);
				check_slverr(got_err, fields[3] != 0);
			end
			"R": begin
				need_fields(line_no, 3);
				apb_xfer(1'b0, APB_ADDR_WIDTH'(fields[0]), 4'h0, 32'h0, got_data, got_err);
				check_rdata(got_data, fields[1]);
				check_slverr(got_err, fields[2] != 0);
			end
			"C": begin
				apb_xfer(1'b1, REG_COMMIT, 4'hf, 32'h0, got_data, got_err);
				check_slverr(got_err, 1'b0);
			end
			"L": begin
				need_fields(line_no, 1);
				@(negedge apb);
				link_up = (fields[0] != 0);
			end
			"T": begin
				need_fields(line_no, 1);
				// Takes effect on the next falling edge
				@(posedge apb);
				// Frames stay queued while tx_ready is held low
				if (tx_mode == 2'd0 && (rx_lens.size() != 0 || in_frame)) begin
					$display("A frame left while tx_ready was held low");
					abort_run();
				end
				tx_mode = 2'(fields[0]);
			end
			"F": begin
				need_fields(line_no, 1);
				n = LEN_WIDTH'(fields[0]);
				if (fields.size() != int'(n) + 1) begin
					$display("Trace line %0d has the wrong number of frame bytes", line_no);
					abort_run();
				end
				exp_lens.push_back(n);
				for (int i = 1; i <= int'(n); i++)
					exp_bytes.push_back(8'(fields[i]));
			end
			"D":
				drain_frames();
			default: begin
				$display("Trace line %0d has an unknown operation", line_no);
				abort_run();
			end
		endcase
	endtask

	////////////////////////////////////////
	// Background processes

	// tx_ready follows the selected mode
	always @(negedge apb) begin
		case (tx_mode)
			2'd0: tx_ready = 1'b0;
			2'd1: tx_ready = 1'b1;
			default: begin
				rnd = $random(seed);
				tx_ready = rnd[0];
			end
		endcase
	end

	// Frame monitor, outputs are stable at the falling edge
	always @(negedge apb) begin
		if (rst_n) begin
			if (tx_valid) begin
				if (tx_start) begin
					if (in_frame)
						rx_lens.push_back(cur_len);
					in_frame = 1'b1;
					cur_len = LEN_WIDTH'(1);
				end else if (!in_frame) begin
					$display("A byte came out on tx_data without tx_start before it");
					abort_run();
				end else begin
					cur_len = cur_len + 1'b1;
				end
				rx_bytes.push_back(tx_data);
			end else if (in_frame) begin
				rx_lens.push_back(cur_len);
				in_frame = 1'b0;
			end
		end
	end

	// Watchdog and bound assertion watch
	always @(negedge apb) begin
		cycles++;
		if (dut.u_props.fail_count != 0) begin
			$display("A bound assertion on the DUT failed");
			abort_run();
		end else if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("The run took more than %0d cycles and was stopped", cycle_limit);
			abort_run();
		end
	end

	////////////////////////////////////////
	// Main flow

	initial begin : main_flow
		int    fd;
		int    line_no;
		int    line_total;
		string line;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pstrb = 4'h0;
		link_up = 1'b0;

		// First pass sizes the watchdog
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the trace file %s", TRACE_FILE);
			abort_run();
		end
		line_total = 0;
		while ($fgets(line, fd) != 0)
			line_total++;
		$fclose(fd);
		cycle_limit = LINE_CYCLES * line_total;

		fd = $fopen(TRACE_FILE, "r");
		wait (rst_n === 1'b1);
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			split_fields(line);
			if (op != 8'h00 && op != "#")
				run_op(line_no);
		end
		$fclose(fd);

		// Quiet window catches frames nobody committed
		repeat (20) @(negedge apb);
		if (rx_lens.size() != 0 || in_frame) begin
			$display("A frame came out that the trace does not expect");
			abort_run();
		end

		if (dut.u_props.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("A bound assertion on the DUT failed");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- eth_tx_trace.txt
# All values hex. W addr strb data err | R addr data err | C | L link | D
# T mode (0 low, 1 high, 2 random) | F length byte0 byte1 ...
L 1
T 1
R 000 00000001 0
W 000 f 12345678 1
R 004 00000000 1
R 010 00000000 1
W 008 f deadbeef 0
C
# Strobes of one to four bytes
W 010 1 123456a0 0
W 014 3 9999b2b1 0
W 018 7 77c3c2c1 0
W 7fc f d4d3d2d1 0
C
F 0a a0 b1 b2 c1 c2 c3 d1 d2 d3 d4
D
# Frames held while tx_ready is low
T 0
W 020 f 13121110 0
W 024 1 00000014 0
C
W 030 3 00002221 0
W 034 1 00000023 0
C
W 040 f 33323130 0
C
R 000 00000001 0
R 000 00000001 0
T 1
F 05 10 11 12 13 14
F 03 21 22 23
F 04 30 31 32 33
D
# Byte FIFO fills, pready stalls until the sender drains
T 0
W 100 f 03020100 0
W 100 f 07060504 0
W 100 f 0b0a0908 0
W 100 f 0f0e0d0c 0
W 100 f 13121110 0
W 100 f 17161514 0
W 100 f 1b1a1918 0
C
W 100 f 43424140 0
T 2
W 100 f 47464544 0
W 100 f 4b4a4948 0
W 100 1 0000004c 0
C
F 1c 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b
F 0d 40 41 42 43 44 45 46 47 48 49 4a 4b 4c
D
# Link drop discards the partial frame
T 1
W 200 f 5a5a5a5a 0
W 204 3 00005b5b 0
L 0
R 000 00000000 0
W 208 f 5c5c5c5c 0
L 1
R 000 00000001 0
W 210 f 63626160 0
W 214 1 00000064 0
C
F 05 60 61 62 63 64
D
C

//--- build.f
eth_tx_pkg.sv
sync_fifo.sv
apb_tx_regs.sv
frame_sender.sv
eth_tx_buffer.sv
tb_clock_gen.sv
eth_tx_buffer_properties.sv
eth_tx_buffer_tb.sv

//--- Bender.yml
package:
  name: eth_tx_buffer

sources:
  - eth_tx_pkg.sv
  - sync_fifo.sv
  - apb_tx_regs.sv
  - frame_sender.sv
  - eth_tx_buffer.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - eth_tx_buffer_properties.sv
      - eth_tx_buffer_tb.sv
